// ==== asg_consts.svh ====
/* Widths and register map for one generator channel.
   The pointer is unsigned fixed point, ASG_CWM integer bits over ASG_CWF fraction bits.
   Word addresses with ASG_BUF_BIT set go to the sample table window. */

`ifndef ASG_CONSTS_SVH
`define ASG_CONSTS_SVH

//////////////////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////////////////

`define ASG_DWO     14  // signed DAC sample
`define ASG_CWM     10  // table address, 1024 entries
`define ASG_CWF     16  // pointer fraction
`define ASG_PW      26  // full pointer, CWM + CWF
`define ASG_WB_AW   11  // wishbone word address
`define ASG_BUF_BIT 10  // set -> table window

//////////////////////////////////////////////////////////////
// register word offsets
//////////////////////////////////////////////////////////////

`define ASG_REG_CTL  0  // abort, sw trigger, trigger select, wrap
`define ASG_REG_SIZE 1  // last valid pointer value
`define ASG_REG_STEP 2  // pointer increment
`define ASG_REG_OFFS 3  // start pointer
`define ASG_REG_NCYC 4  // table passes per burst
`define ASG_REG_RNUM 5  // extra bursts
`define ASG_REG_RDLY 6  // idle cycles between bursts
`define ASG_REG_STAT 7  // bit0 busy

`endif

// ==== asg_pkg.sv ====
/* Bus, configuration and table port types shared by the generator blocks.
   Field widths come from asg_consts.svh. */

`default_nettype none

`include "asg_consts.svh"

package asg_pkg;

  //////////////////////////////////////////////////////////////
  // wishbone classic
  //////////////////////////////////////////////////////////////

  // master side request
  typedef struct packed {
    logic                   cyc;  // bus cycle
    logic                   stb;  // strobe
    logic                   we;   // write enable
    logic [`ASG_WB_AW-1:0]  adr;  // word address
    logic [31:0]            dat;  // write data
  } wb_req_t;

  // slave side response
  typedef struct packed {
    logic        ack;  // one cycle
    logic [31:0] dat;  // read data, valid with ack
  } wb_rsp_t;

  //////////////////////////////////////////////////////////////
  // channel setup and table port
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`ASG_PW-1:0] size;  // last pointer before wrap
    logic [`ASG_PW-1:0] step;  // added each sample
    logic [`ASG_PW-1:0] offs;  // start phase
    logic [15:0]        ncyc;  // passes per burst
    logic [15:0]        rnum;  // repetitions after the first burst
    logic [31:0]        rdly;  // gap between bursts
    logic               wrap;  // keep remainder on wrap
  } asg_cfg_t;

  typedef struct packed {
    logic                       ena;    // single cycle strobe
    logic                       wen;    // write, else read
    logic [`ASG_CWM-1:0]        addr;   // table entry
    logic signed [`ASG_DWO-1:0] wdata;  // sample to store
  } asg_buf_t;

endpackage

`default_nettype wire

// ==== asg_trig.sv ====
/* Trigger front end. trg_pin may be asynchronous and must stay high for
   more than one clock to be seen. Only its rising edge counts. */

`timescale 1ns/100ps
`default_nettype none

module asg_trig (
  input  logic clk,
  input  logic rstn,
  input  logic trg_pin,  // external trigger, async
  input  logic sw_trg,   // register write pulse
  input  logic trg_sel,  // 1 picks the pin
  output logic trg       // single cycle event
);

  //////////////////////////////////////////////////////////////
  // pin synchronizer and edge detect
  //////////////////////////////////////////////////////////////

  logic [1:0] pin_sync;  // two flop synchronizer
  logic       pin_dly;   // previous synchronized level
  logic       pin_edge;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pin_sync <= 2'b00;
      pin_dly  <= 1'b0;
    end else begin
      pin_sync <= {pin_sync[0], trg_pin};
      pin_dly  <= pin_sync[1];
    end
  end

  assign pin_edge = pin_sync[1] & ~pin_dly;  // rising edge only

  //////////////////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////////////////

  // sw path has no added delay
  assign trg = trg_sel ? pin_edge : sw_trg;

endmodule

`default_nettype wire

// ==== asg_regs.sv ====
/* Wishbone classic register slave for one channel. Each access gets one ack,
   one clock after the request. The master must drop stb after ack.
   Table reads return the sample sign-extended to 32 bits. */

`timescale 1ns/100ps
`default_nettype none

`include "asg_consts.svh"

module asg_regs (
  input  logic                       clk,
  input  logic                       rstn,
  input  asg_pkg::wb_req_t           wb_req,
  output asg_pkg::wb_rsp_t           wb_rsp,
  output asg_pkg::asg_cfg_t          cfg,
  output asg_pkg::asg_buf_t          buf_req,
  input  logic signed [`ASG_DWO-1:0] buf_rdata,  // table read, one cycle after ena
  input  logic                       busy,
  output logic                       ctl_rst,    // abort pulse
  output logic                       sw_trg,     // trigger pulse
  output logic                       trg_sel     // 1 = external pin
);

  //////////////////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////////////////

  logic        ack;
  logic        acc;      // new access this cycle
  logic        wr;
  logic        rd;
  logic        is_buf;   // table window
  logic        rd_buf;   // last read went to the table
  logic [31:0] rd_word;  // registered register read

  assign acc    = wb_req.cyc & wb_req.stb & ~ack;  // once per request
  assign is_buf = wb_req.adr[`ASG_BUF_BIT];
  assign wr     = acc & wb_req.we & ~is_buf;
  assign rd     = acc & ~wb_req.we & ~is_buf;

  // table port strobes in the same cycle, data back with ack
  always_comb begin
    buf_req.ena   = acc & is_buf;
    buf_req.wen   = wb_req.we;
    buf_req.addr  = wb_req.adr[`ASG_CWM-1:0];
    buf_req.wdata = $signed(wb_req.dat[`ASG_DWO-1:0]);
  end

  //////////////////////////////////////////////////////////////
  // ack and control pulses
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ack     <= 1'b0;
      rd_buf  <= 1'b0;
      ctl_rst <= 1'b0;
      sw_trg  <= 1'b0;
    end else begin
      ack     <= acc;
      if (acc) rd_buf <= is_buf;  // steers read data
      // pulses line up with the write ack
      ctl_rst <= wr & (wb_req.adr[`ASG_BUF_BIT-1:0] == `ASG_REG_CTL) & wb_req.dat[0];
      sw_trg  <= wr & (wb_req.adr[`ASG_BUF_BIT-1:0] == `ASG_REG_CTL) & wb_req.dat[1];
    end
  end

  //////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg     <= '0;
      trg_sel <= 1'b0;
    end else if (wr) begin
      case (wb_req.adr[`ASG_BUF_BIT-1:0])
        `ASG_REG_CTL: begin
          trg_sel  <= wb_req.dat[2];
          cfg.wrap <= wb_req.dat[3];
        end
        `ASG_REG_SIZE: cfg.size <= wb_req.dat[`ASG_PW-1:0];
        `ASG_REG_STEP: cfg.step <= wb_req.dat[`ASG_PW-1:0];
        `ASG_REG_OFFS: cfg.offs <= wb_req.dat[`ASG_PW-1:0];
        `ASG_REG_NCYC: cfg.ncyc <= wb_req.dat[15:0];
        `ASG_REG_RNUM: cfg.rnum <= wb_req.dat[15:0];
        `ASG_REG_RDLY: cfg.rdly <= wb_req.dat;
        default: ;  // stat is read only
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd) begin
      case (wb_req.adr[`ASG_BUF_BIT-1:0])
        `ASG_REG_CTL:  rd_word <= {28'd0, cfg.wrap, trg_sel, 2'b00};  // pulse bits read 0
        `ASG_REG_SIZE: rd_word <= {{(32-`ASG_PW){1'b0}}, cfg.size};
        `ASG_REG_STEP: rd_word <= {{(32-`ASG_PW){1'b0}}, cfg.step};
        `ASG_REG_OFFS: rd_word <= {{(32-`ASG_PW){1'b0}}, cfg.offs};
        `ASG_REG_NCYC: rd_word <= {16'd0, cfg.ncyc};
        `ASG_REG_RNUM: rd_word <= {16'd0, cfg.rnum};
        `ASG_REG_RDLY: rd_word <= cfg.rdly;
        `ASG_REG_STAT: rd_word <= {31'd0, busy};
        default:       rd_word <= 32'd0;  // unmapped
      endcase
    end
  end

  always_comb begin
    wb_rsp.ack = ack;
    wb_rsp.dat = rd_buf ? {{(32-`ASG_DWO){buf_rdata[`ASG_DWO-1]}}, buf_rdata} : rd_word;
  end

endmodule

`default_nettype wire

// ==== asg.sv ====
/* One generator channel with sample table, pointer FSM and output pipe.
   Settings are sampled live, so change them only while idle.
   Assumes step <= size + 1 so the pointer wraps at most once per sample. */

`timescale 1ns/100ps
`default_nettype none

`include "asg_consts.svh"

module asg (
  input  logic                       clk,
  input  logic                       rstn,
  input  asg_pkg::asg_cfg_t          cfg,
  input  logic                       ctl_rst,    // abort to idle
  input  logic                       trg,        // start event
  input  asg_pkg::asg_buf_t          buf_req,    // cpu table access
  output logic signed [`ASG_DWO-1:0] buf_rdata,
  output logic signed [`ASG_DWO-1:0] sto_dat,
  output logic                       sto_vld,
  input  logic                       sto_rdy,
  output logic                       trg_o,      // burst started by trg
  output logic                       busy
);

  //////////////////////////////////////////////////////////////
  // sample table
  //////////////////////////////////////////////////////////////

  logic signed [`ASG_DWO-1:0] mem [0:2**`ASG_CWM-1];
  logic [`ASG_CWM-1:0]        raddr;  // stage 1 address
  logic                       v1;     // stage 1 valid
  logic                       adv;    // pipe moves

  // cpu port, write or read
  always_ff @(posedge clk) begin
    if (buf_req.ena) begin
      if (buf_req.wen) mem[buf_req.addr] <= buf_req.wdata;
      else             buf_rdata <= mem[buf_req.addr];
    end
  end

  //////////////////////////////////////////////////////////////
  // pointer and repetition FSM
  //////////////////////////////////////////////////////////////

  logic [`ASG_PW-1:0] pnt;       // current read pointer
  logic [`ASG_PW:0]   npnt;      // next pointer, one extra bit
  logic [`ASG_PW:0]   nsub;      // next pointer past the table end
  logic               wrap_hit;  // next pointer beyond size
  logic               last;      // final pointer of the burst
  logic               run;       // issuing pointers
  logic               rep_wait;  // gap between bursts
  logic               start;
  logic               restart;
  logic [15:0]        cyc_cnt;   // passes left
  logic [15:0]        rep_cnt;   // bursts left after this one
  logic [31:0]        dly_cnt;

  assign adv      = ~sto_vld | sto_rdy;  // output free or taken
  assign npnt     = {1'b0, pnt} + {1'b0, cfg.step};
  assign nsub     = npnt - {1'b0, cfg.size} - 1'b1;
  assign wrap_hit = ~nsub[`ASG_PW];  // sign clear -> npnt > size
  assign last     = wrap_hit & (cyc_cnt <= 16'd1);  // ncyc 0 acts as 1

  assign start   = trg & ~run & ~rep_wait;
  assign restart = rep_wait & (dly_cnt == 32'd0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      run      <= 1'b0;
      rep_wait <= 1'b0;
      pnt      <= '0;
      cyc_cnt  <= '0;
      rep_cnt  <= '0;
      dly_cnt  <= '0;
      trg_o    <= 1'b0;
    end else begin
      trg_o <= start & ~ctl_rst;  // external starts only
      if (ctl_rst) begin
        run      <= 1'b0;
        rep_wait <= 1'b0;
        rep_cnt  <= '0;
        dly_cnt  <= '0;
      end else if (start) begin
        run     <= 1'b1;
        pnt     <= cfg.offs;
        cyc_cnt <= cfg.ncyc;
        rep_cnt <= cfg.rnum;
      end else if (restart) begin
        // next repetition, no trigger needed
        run      <= 1'b1;
        rep_wait <= 1'b0;
        pnt      <= cfg.offs;
        cyc_cnt  <= cfg.ncyc;
      end else if (rep_wait) begin
        dly_cnt <= dly_cnt - 32'd1;
      end else if (run && adv) begin
        if (last) begin
          run <= 1'b0;
          if (rep_cnt != 16'd0) begin
            rep_wait <= 1'b1;
            rep_cnt  <= rep_cnt - 16'd1;
            dly_cnt  <= cfg.rdly;
          end
        end else if (wrap_hit) begin
          pnt     <= cfg.wrap ? nsub[`ASG_PW-1:0] : cfg.offs;  // keep phase or restart
          cyc_cnt <= cyc_cnt - 16'd1;
        end else begin
          pnt <= npnt[`ASG_PW-1:0];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // two stage output pipe
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1      <= 1'b0;
      sto_vld <= 1'b0;
    end else if (ctl_rst) begin
      v1      <= 1'b0;  // drop samples in flight
      sto_vld <= 1'b0;
    end else if (adv) begin
      v1      <= run;
      sto_vld <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      raddr   <= pnt[`ASG_CWF +: `ASG_CWM];  // integer part
      sto_dat <= mem[raddr];                 // held under stall
    end
  end

  // high until the last sample leaves
  assign busy = run | rep_wait | v1 | sto_vld;

endmodule

`default_nettype wire

// ==== asg_top.sv ====
/* Generator top level with one channel behind a Wishbone register slave.
   The trigger source is chosen by CTL bit 2. The DAC stream uses valid/ready. */

`timescale 1ns/100ps
`default_nettype none

`include "asg_consts.svh"

module asg_top (
  input  logic                       clk,
  input  logic                       rstn,
  input  asg_pkg::wb_req_t           wb_req,
  output asg_pkg::wb_rsp_t           wb_rsp,
  input  logic                       trg_pin,  // external trigger
  output logic signed [`ASG_DWO-1:0] sto_dat,
  output logic                       sto_vld,
  input  logic                       sto_rdy,
  output logic                       trg_o
);

  asg_pkg::asg_cfg_t          cfg;
  asg_pkg::asg_buf_t          buf_req;
  logic signed [`ASG_DWO-1:0] buf_rdata;
  logic                       busy;
  logic                       ctl_rst;
  logic                       sw_trg;
  logic                       trg_sel;
  logic                       trg;

  // bus side
  asg_regs u_regs (
    .clk       (clk),
    .rstn      (rstn),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cfg       (cfg),
    .buf_req   (buf_req),
    .buf_rdata (buf_rdata),
    .busy      (busy),
    .ctl_rst   (ctl_rst),
    .sw_trg    (sw_trg),
    .trg_sel   (trg_sel)
  );

  asg_trig u_trig (
    .clk     (clk),
    .rstn    (rstn),
    .trg_pin (trg_pin),
    .sw_trg  (sw_trg),
    .trg_sel (trg_sel),
    .trg     (trg)
  );

  // channel
  asg u_asg (
    .clk       (clk),
    .rstn      (rstn),
    .cfg       (cfg),
    .ctl_rst   (ctl_rst),
    .trg       (trg),
    .buf_req   (buf_req),
    .buf_rdata (buf_rdata),
    .sto_dat   (sto_dat),
    .sto_vld   (sto_vld),
    .sto_rdy   (sto_rdy),
    .trg_o     (trg_o),
    .busy      (busy)
  );

endmodule

`default_nettype wire

// ==== asg_checker.sv ====
/* Protocol assertions for asg_top, attached with bind.
   Covers the Wishbone ack width and the DAC stream hold rule. */

`timescale 1ns/100ps
`default_nettype none

`include "asg_consts.svh"

module asg_checker (
  input logic                       clk,
  input logic                       rstn,
  input logic                       ack,
  input logic signed [`ASG_DWO-1:0] sto_dat,
  input logic                       sto_vld,
  input logic                       sto_rdy
);

  // single cycle ack per access
  ack_pulse: assert property (@(posedge clk) disable iff (!rstn) ack |=> !ack)
    else $error("wishbone ack high for two cycles");

  // stalled sample must not move
  dat_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> $stable(sto_dat))
    else $error("sto_dat changed while stalled");

  rst_vld: assert property (@(posedge clk) !rstn |=> !sto_vld)  // sync reset
    else $error("sto_vld high after reset");

endmodule

bind asg_top asg_checker u_checker (
  .clk     (clk),
  .rstn    (rstn),
  .ack     (wb_rsp.ack),
  .sto_dat (sto_dat),
  .sto_vld (sto_vld),
  .sto_rdy (sto_rdy)
);

`default_nettype wire

// ==== asg_tb.sv ====
/* Testbench for asg_top. Bus and stream inputs change on the falling edge.
   Checks sample order and count against a model of the table walk, not latency. */

`timescale 1ns/100ps
`default_nettype none

`include "asg_consts.svh"

module asg_tb;

  typedef struct packed {
    logic [7:0]  n;     // table length
    logic [7:0]  step;  // integer pointer step
    logic [7:0]  offs;  // integer start offset
    logic [15:0] ncyc;
    logic [15:0] rnum;
    logic [15:0] rdly;
    logic        wrap;
    logic        pin;   // external trigger
    logic        bp;    // random sto_rdy
    logic        abrt;  // abort mid burst
  } row_t;

  logic                       clk = 1'b0;
  logic                       rstn;
  asg_pkg::wb_req_t           wb_req;
  asg_pkg::wb_rsp_t           wb_rsp;
  logic                       trg_pin;
  logic signed [`ASG_DWO-1:0] sto_dat;
  logic                       sto_vld;
  logic                       sto_rdy = 1'b1;
  logic                       trg_o;

  row_t                       rows [0:6];
  string                      names [0:6];
  logic signed [`ASG_DWO-1:0] tbl [0:63];  // first 64 table entries
  logic signed [`ASG_DWO-1:0] exp_q [$];   // model samples
  logic signed [`ASG_DWO-1:0] rx_q [$];    // transferred samples
  logic [31:0]                lfsr;
  logic                       bp_on;
  int                         errors;
  int                         checks;
  int                         cycles = 0;
  int                         limit;
  int                         trg_cnt;

  asg_top uut (
    .clk     (clk),
    .rstn    (rstn),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .trg_pin (trg_pin),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy),
    .trg_o   (trg_o)
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////////////////
  // random bits, monitors, run limit
  //////////////////////////////////////////////////////////////

  // fibonacci with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[31]};
      lfsr = lfsr_step(lfsr);  // one step per bit
    end
    return r;
  endfunction

  always @(negedge clk) sto_rdy <= bp_on ? (rand_bits(1) != 0) : 1'b1;

  // values from before the edge
  always @(posedge clk) begin
    if (rstn && sto_vld && sto_rdy) rx_q.push_back(sto_dat);
    if (rstn && trg_o) trg_cnt++;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run hung after %0d cycles, limit %0d", cycles, limit);
      errors++;
      end_run();
    end
  end

  task end_run();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  task automatic compare_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // wishbone master, one access at a time
  //////////////////////////////////////////////////////////////

  task automatic wb_write(input logic [10:0] adr, input logic [31:0] dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do @(negedge clk); while (!wb_rsp.ack);
    wb_req.cyc = 1'b0;  // drop after ack
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_read(input logic [10:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    do @(negedge clk); while (!wb_rsp.ack);
    dat        = wb_rsp.dat;  // valid with ack
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////
  // reference model of the table walk
  //////////////////////////////////////////////////////////////

  task automatic build_model(input row_t r);
    int p;
    int np;
    int cnt;
    bit done;
    exp_q.delete();
    for (int b = 0; b <= r.rnum; b++) begin  // rnum+1 bursts
      p    = r.offs;
      cnt  = (r.ncyc == 0) ? 1 : r.ncyc;
      done = 1'b0;
      while (!done) begin
        exp_q.push_back(tbl[p]);
        np = p + r.step;
        if (np >= r.n) begin  // one pass over the table done
          if (cnt <= 1) done = 1'b1;
          else begin
            cnt--;
            p = r.wrap ? np - r.n : r.offs;
          end
        end else p = np;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////

  task automatic regs_test();
    logic [10:0] adr [0:6];
    logic [31:0] val [0:6];
    logic [31:0] d;
    adr = '{11'd1, 11'd2, 11'd3, 11'd4, 11'd5, 11'd6, 11'd0};  // size .. rdly, ctl
    val = '{32'h0155_aaaa, 32'h0012_3456, 32'h02ab_cdef, 32'h0000_beef,
            32'h0000_1234, 32'hdead_beef, 32'h0000_000c};  // ctl sets sel and wrap
    for (int i = 0; i < 7; i++) wb_write(adr[i], val[i]);
    for (int i = 0; i < 7; i++) begin
      wb_read(adr[i], d);
      compare_val($sformatf("reg %0d", adr[i]), val[i], d);
    end
    wb_read(`ASG_REG_STAT, d);
    compare_val("stat idle", 32'd0, d);
  endtask

  task automatic table_test();
    logic [31:0] d;
    for (int a = 0; a < 64; a++) begin
      d      = rand_bits(`ASG_DWO);
      tbl[a] = d[`ASG_DWO-1:0];
      wb_write({1'b1, 10'(a)}, {{(32-`ASG_DWO){tbl[a][`ASG_DWO-1]}}, tbl[a]});
    end
    for (int a = 0; a < 64; a++) begin
      wb_read({1'b1, 10'(a)}, d);
      compare_val($sformatf("table %0d", a), int'(tbl[a]), d);  // signed value
    end
  endtask

  task automatic run_row(input int i);
    row_t        r;
    logic [31:0] ctl;
    logic [31:0] d;
    r = rows[i];
    build_model(r);
    rx_q.delete();
    trg_cnt = 0;
    bp_on   = r.bp;
    wb_write(`ASG_REG_SIZE, {8'd0, r.n, 16'd0} - 32'd1);  // last pointer
    wb_write(`ASG_REG_STEP, {8'd0, r.step, 16'd0});
    wb_write(`ASG_REG_OFFS, {8'd0, r.offs, 16'd0});
    wb_write(`ASG_REG_NCYC, {16'd0, r.ncyc});
    wb_write(`ASG_REG_RNUM, {16'd0, r.rnum});
    wb_write(`ASG_REG_RDLY, {16'd0, r.rdly});
    ctl = {28'd0, r.wrap, r.pin, 2'b00};
    if (r.pin) begin
      wb_write(`ASG_REG_CTL, ctl);
      @(negedge clk) trg_pin = 1'b1;  // level held past the burst end
    end else begin
      wb_write(`ASG_REG_CTL, ctl | 32'h2);  // software trigger
    end
    if (r.abrt) begin
      while (rx_q.size() < 20) @(negedge clk);
      wb_write(`ASG_REG_CTL, ctl | 32'h1);
      repeat (4) @(negedge clk);
      repeat (10) begin
        @(negedge clk);
        compare_val({names[i], " vld after abort"}, 32'd0, sto_vld);
      end
      if (rx_q.size() >= exp_q.size()) begin
        errors++;
        $display("%s: abort did not stop the burst early", names[i]);
      end
    end else begin
      while (rx_q.size() < exp_q.size()) @(negedge clk);
      repeat (20) @(negedge clk);  // room for stray samples
      compare_val({names[i], " count"}, exp_q.size(), rx_q.size());
    end
    for (int k = 0; k < rx_q.size() && k < exp_q.size(); k++)
      compare_val($sformatf("%s sample %0d", names[i], k), exp_q[k], rx_q[k]);
    wb_read(`ASG_REG_STAT, d);
    compare_val({names[i], " busy"}, 32'd0, {31'd0, d[0]});
    compare_val({names[i], " trg_o pulses"}, 32'd1, trg_cnt);
    trg_pin = 1'b0;
    bp_on   = 1'b0;
  endtask

  initial begin
    rstn    = 1'b0;
    wb_req  = '0;
    trg_pin = 1'b0;
    bp_on   = 1'b0;
    lfsr    = 32'h4622_91b7;
    errors  = 0;
    checks  = 0;
    trg_cnt = 0;
    // n, step, offs, ncyc, rnum, rdly, wrap, pin, bp, abort
    names[0] = "sw_single";
    rows[0]  = '{8'd16, 8'd1, 8'd0, 16'd1, 16'd0, 16'd0, 1'b0, 1'b0, 1'b0, 1'b0};
    names[1] = "sw_wrap";
    rows[1]  = '{8'd20, 8'd3, 8'd2, 16'd3, 16'd0, 16'd0, 1'b1, 1'b0, 1'b0, 1'b0};
    names[2] = "sw_nowrap";
    rows[2]  = '{8'd24, 8'd5, 8'd4, 16'd2, 16'd0, 16'd0, 1'b0, 1'b0, 1'b0, 1'b0};
    names[3] = "pin_trig";
    rows[3]  = '{8'd32, 8'd2, 8'd1, 16'd2, 16'd0, 16'd0, 1'b1, 1'b1, 1'b0, 1'b0};
    names[4] = "repeat";
    rows[4]  = '{8'd12, 8'd1, 8'd3, 16'd2, 16'd2, 16'd7, 1'b1, 1'b0, 1'b0, 1'b0};
    names[5] = "backpressure";
    rows[5]  = '{8'd40, 8'd3, 8'd5, 16'd4, 16'd1, 16'd3, 1'b1, 1'b0, 1'b1, 1'b0};
    names[6] = "abort";
    rows[6]  = '{8'd64, 8'd1, 8'd0, 16'd4, 16'd0, 16'd0, 1'b1, 1'b0, 1'b0, 1'b1};
    limit = 2000;
    for (int i = 0; i < 7; i++) begin
      build_model(rows[i]);  // only the count matters here
      limit += exp_q.size() * 4 + (rows[i].rnum + 1) * (rows[i].rdly + 20);
    end
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    regs_test();
    table_test();
    for (int i = 0; i < 7; i++) run_row(i);
    end_run();
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
asg_pkg.sv
asg_trig.sv
asg_regs.sv
asg.sv
asg_top.sv
asg_checker.sv
asg_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the generator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module asg_tb -f build.f -o asg_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/asg_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$log"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
